// ==== Makefile ====
# Verilator build and run of the memory stage testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module memSubsystemTb -f project.f -o simv

run: compile
	@out=$$(./obj_dir/simv); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

// ==== project.f ====
verilog/mipsIsaPkg.sv
verilog/memMapPkg.sv
verilog/cp0Port.sv
verilog/storeAlign.sv
verilog/coprocessor0.sv
verilog/dataMemory.sv
verilog/memStage.sv
verilog/memSubsystem.sv
test/memSubsystemTb.sv

// ==== test/memStimulus.txt ====
# test stall flush op pc addr rtData rtAddr rdAddr destAddr destData tNew wbAddr wbData bd hwInt
# then expected: kCtrl epc isBd opWb pcWb memWordWb offsetWb destAddrWb destDataWb tNewWb mask
1 0 0 6 400 100 11223344 3 0 0 0 0 0 0 0 0 0 3000 0 6 400 0 0 0 0 0 3df
1 0 0 7 404 102 0000aabb 3 0 0 0 0 0 0 0 0 0 3000 0 7 404 0 2 0 0 0 3df
1 0 0 8 408 101 cc 3 0 0 0 0 0 0 0 0 0 3000 0 8 408 0 1 0 0 0 3df
1 0 0 1 40c 100 0 0 0 5 0 2 0 0 0 0 0 3000 0 1 40c aabbcc44 0 5 aabbcc44 1 3ff
1 0 0 4 410 103 0 0 0 6 0 1 0 0 0 0 0 3000 0 4 410 aabbcc44 3 6 aabbcc44 0 3ff
2 0 0 1 500 102 0 0 0 5 0 0 0 0 0 0 1 3000 0 1 500 aabbcc44 2 5 aabbcc44 0 3ff
2 0 0 9 504 0 0 0 d 8 0 0 0 0 0 0 0 500 0 9 504 0 0 8 10 0 3df
2 0 0 9 508 0 0 0 c 8 0 0 0 0 0 0 0 500 0 9 508 0 0 8 fc03 0 3df
2 0 0 8 50c 3000 ff 3 0 0 0 0 0 0 0 0 1 500 0 8 50c 0 0 0 0 0 3df
2 0 0 9 510 0 0 0 d 8 0 0 0 0 0 0 0 50c 0 9 510 0 0 8 14 0 3df
2 0 0 7 514 101 1234 3 0 0 0 0 0 0 0 0 1 50c 0 7 514 0 1 0 0 0 3df
2 0 0 1 518 100 0 0 0 9 0 0 0 0 0 0 0 514 0 1 518 aabbcc44 0 9 aabbcc44 0 3ff
3 0 0 a 600 0 2abf 4 e 0 0 0 0 0 0 0 0 514 0 a 600 0 0 0 0 0 3df
3 0 0 9 604 0 0 0 e a 0 0 0 0 0 0 0 2abc 0 9 604 0 0 a 2abc 0 3df
3 0 0 b 608 0 0 0 0 0 0 0 0 0 0 0 2 2abc 0 b 608 0 0 0 0 0 3df
3 0 0 9 60c 0 0 0 f b 0 0 0 0 0 0 0 2abc 0 9 60c 0 0 b 4d50 0 3df
4 0 0 c 700 0 0 0 0 2 1234 1 0 0 1 4 1 2abc 1 c 700 0 0 2 1234 0 3df
4 0 0 9 704 0 0 0 d 8 0 0 0 0 0 4 0 6fc 0 9 704 0 0 8 80001000 0 3df
4 0 0 a 708 0 1 5 c 0 0 0 0 0 0 4 0 6fc 0 a 708 0 0 0 0 0 3df
4 0 0 c 70c 0 0 0 0 2 0 0 0 0 0 4 0 6fc 0 c 70c 0 0 2 0 0 3df
5 0 0 6 800 200 11111111 7 0 0 0 0 7 77777777 0 0 0 6fc 0 6 800 0 0 0 0 0 3df
5 0 0 6 804 204 22222222 0 0 0 0 0 0 99999999 0 0 0 6fc 0 6 804 0 0 0 0 0 3df
5 0 0 1 808 200 0 0 0 3 0 0 0 0 0 0 0 6fc 0 1 808 77777777 0 3 77777777 0 3ff
5 0 0 1 80c 204 0 0 0 3 0 0 0 0 0 0 0 6fc 0 1 80c 22222222 0 3 22222222 0 3ff
6 1 0 6 900 200 55555555 2 0 0 0 0 0 0 0 0 0 6fc 0 1 80c 22222222 0 3 22222222 0 3ff
6 0 0 1 904 200 0 0 0 4 0 3 0 0 0 0 0 6fc 0 1 904 77777777 0 4 77777777 2 3ff
6 0 1 c 908 0 0 0 0 5 abc 2 0 0 0 0 0 6fc 0 0 0 0 0 0 0 0 3ff
6 0 0 c 90c 0 0 0 0 1 1 0 0 0 0 0 0 6fc 0 c 90c 0 0 1 1 0 3ff

// ==== test/memSubsystemTb.sv ====
`timescale 1ns/10ps

module memSubsystemTb;
    import mipsIsaPkg::*;
    import memMapPkg::*;

    // Columns of a stimulus line, the inputs first and then the expected outputs
    typedef enum int {
        colTest, colStall, colFlush, colOp, colPc, colAddr, colRtData, colRtAddr,
        colRdAddr, colDestAddr, colDestData, colTNew, colWbAddr, colWbData, colBd, colHwInt,
        colKCtrl, colEpc, colIsBd, colOpWb, colPcWb, colMemWordWb, colOffsetWb,
        colDestAddrWb, colDestDataWb, colTNewWb, colMask, numCols
    } column;

    localparam int maxRows = 64;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        flush;
    logic        memDisable;
    memOp        op;
    logic [31:0] pc;
    excCode      excIn;
    logic [31:0] aluOut;
    logic [31:0] rtData;
    logic [4:0]  rtAddr;
    logic [4:0]  rdAddr;
    logic [4:0]  destAddr;
    logic [31:0] destData;
    tNewType     tNew;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    logic [31:0] macroPc;
    logic        macroBd;
    logic [5:0]  hwInt;
    memOp        opWb;
    logic [31:0] pcWb;
    logic [31:0] memWordWb;
    logic [1:0]  offsetWb;
    logic [4:0]  destAddrWb;
    logic [31:0] destDataWb;
    tNewType     tNewWb;
    kCtrlKind    kCtrl;
    logic [31:2] epc;
    logic        isBd;

    logic [31:0] stim [maxRows][numCols];
    int          rowCount = 0;
    int          errors = 0;
    int          checks = 0;
    int          testErrors = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    int          cycles = 0;
    int          cycleLimit = maxRows * 4 + 100;
    bit          fileOk;

    memSubsystem #(
        .memWords (3072)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout, the run did not finish within %0d cycles", cycleLimit);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic loadStimulus();
        int          fd;
        int          got;
        string       text;
        logic [31:0] v [numCols];
        fd = $fopen("test/memStimulus.txt", "r");
        fileOk = (fd != 0);
        if (fileOk) begin
            while (!$feof(fd) && rowCount < maxRows) begin
                text = "";
                void'($fgets(text, fd));
                // Skip blank lines and the column legend
                if (text.len() > 1 && text[0] != "#") begin
                    got = $sscanf(text,
                        "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                        v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18],
                        v[19], v[20], v[21], v[22], v[23], v[24], v[25], v[26]);
                    if (got == numCols) begin
                        for (int c = 0; c < numCols; c++) begin
                            stim[rowCount][c] = v[c];
                        end
                        rowCount++;
                    end else begin
                        $display("stimulus line has too few values: %s", text);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic idleInputs();
        stall      <= 1'b0;
        flush      <= 1'b0;
        memDisable <= 1'b0;
        op         <= opNop;
        pc         <= 32'h0;
        excIn      <= excNone;
        aluOut     <= 32'h0;
        rtData     <= 32'h0;
        rtAddr     <= 5'd0;
        rdAddr     <= 5'd0;
        destAddr   <= 5'd0;
        destData   <= 32'h0;
        tNew       <= 2'd0;
        wbAddr     <= 5'd0;
        wbData     <= 32'h0;
        macroPc    <= 32'h0;
        macroBd    <= 1'b0;
        hwInt      <= 6'd0;
    endtask

    // Macro PC follows the PC of the instruction held in this stage
    task automatic applyRow(input int r);
        stall    <= stim[r][colStall][0];
        flush    <= stim[r][colFlush][0];
        op       <= memOp'(stim[r][colOp][3:0]);
        pc       <= stim[r][colPc];
        macroPc  <= stim[r][colPc];
        aluOut   <= stim[r][colAddr];
        rtData   <= stim[r][colRtData];
        rtAddr   <= stim[r][colRtAddr][4:0];
        rdAddr   <= stim[r][colRdAddr][4:0];
        destAddr <= stim[r][colDestAddr][4:0];
        destData <= stim[r][colDestData];
        tNew     <= stim[r][colTNew][1:0];
        wbAddr   <= stim[r][colWbAddr][4:0];
        wbData   <= stim[r][colWbData];
        macroBd  <= stim[r][colBd][0];
        hwInt    <= stim[r][colHwInt][5:0];
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
            errors++;
            testErrors++;
        end
    endtask

    // Mask bits 0 to 2 cover the combinational outputs
    task automatic checkComb(input int r);
        if (stim[r][colMask][0]) checkValue("kCtrl", {30'b0, kCtrl}, stim[r][colKCtrl]);
        if (stim[r][colMask][1]) checkValue("epc", {epc, 2'b00}, stim[r][colEpc]);
        if (stim[r][colMask][2]) checkValue("isBd", {31'b0, isBd}, stim[r][colIsBd]);
    endtask

    task automatic checkRegistered(input int r);
        if (stim[r][colMask][3]) checkValue("opWb", {28'b0, opWb}, stim[r][colOpWb]);
        if (stim[r][colMask][4]) checkValue("pcWb", pcWb, stim[r][colPcWb]);
        if (stim[r][colMask][5]) checkValue("memWordWb", memWordWb, stim[r][colMemWordWb]);
        if (stim[r][colMask][6]) checkValue("offsetWb", {30'b0, offsetWb}, stim[r][colOffsetWb]);
        if (stim[r][colMask][7]) begin
            checkValue("destAddrWb", {27'b0, destAddrWb}, stim[r][colDestAddrWb]);
        end
        if (stim[r][colMask][8]) checkValue("destDataWb", destDataWb, stim[r][colDestDataWb]);
        if (stim[r][colMask][9]) checkValue("tNewWb", {30'b0, tNewWb}, stim[r][colTNewWb]);
    endtask

    task automatic closeTest(input logic [31:0] testNo);
        if (testErrors == 0) begin
            testsPassed++;
            $display("test %0d finished without errors", testNo);
        end else begin
            testsFailed++;
            $display("test %0d finished with %0d errors", testNo, testErrors);
        end
        testErrors = 0;
    endtask

    initial begin
        reset = 1'b1;
        idleInputs();
        loadStimulus();
        cycleLimit = rowCount * 4 + 100;
        if (!fileOk) begin
            $display("stimulus file test/memStimulus.txt could not be opened");
            $display("TB FAILED");
            $finish;
        end else begin
            repeat (4) @(posedge clk);
            reset <= 1'b0;
            for (int r = 0; r < rowCount; r++) begin
                applyRow(r);
                @(negedge clk);
                // Registered outputs now hold the previous row
                if (r > 0) begin
                    checkRegistered(r - 1);
                    if (stim[r][colTest] != stim[r - 1][colTest]) begin
                        closeTest(stim[r - 1][colTest]);
                    end
                end
                checkComb(r);
                @(posedge clk);
            end
            idleInputs();
            @(negedge clk);
            if (rowCount > 0) begin
                checkRegistered(rowCount - 1);
                closeTest(stim[rowCount - 1][colTest]);
            end
            $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                testsPassed, testsFailed, checks, errors);
            if (errors == 0 && rowCount > 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

// ==== verilog/coprocessor0.sv ====
`timescale 1ns/10ps

module coprocessor0 (
    input logic clk,
    input logic reset,
    cp0Port.cop bus
);
    import mipsIsaPkg::*;
    import memMapPkg::*;

    // Status fields
    logic [5:0]  im;
    logic        exl;
    logic        ie;

    // Cause fields
    logic        bd;
    logic [5:0]  ip;
    excCode      excCodeReg;

    logic [31:2] epcReg;

    logic [31:0] srWord;
    logic [31:0] causeWord;
    logic        interrupt;
    logic        exception;
    logic        entry;
    logic        isEret;
    logic        isMtc0;
    logic [31:0] entryPc;

    assign srWord    = {16'b0, im, 8'b0, exl, ie};
    assign causeWord = {bd, 15'b0, ip, 3'b0, excCodeReg, 2'b00};

    // Interrupts only outside kernel mode and with IE set
    assign interrupt = (|(im & bus.hwInt)) && ie && !exl;
    assign exception = (bus.exc != excNone);
    assign entry     = interrupt || exception;
    assign isEret    = (bus.op == opEret);
    assign isMtc0    = (bus.op == opMtc0);

    // Restart at the branch when the victim sits in a delay slot
    assign entryPc = bus.macroBd ? (bus.macroPc - 32'd4) : bus.macroPc;

    assign bus.kCtrl = entry ? kCtrlKtext : (isEret ? kCtrlEret : kCtrlNone);
    assign bus.isBd  = entry ? bus.macroBd : 1'b0;
    assign bus.epc   = epcReg;

    always_comb begin
        bus.readData = 32'h0000_0000;
        if (bus.op == opMfc0) begin
            case (bus.regId)
                cp0Sr:    bus.readData = srWord;
                cp0Cause: bus.readData = causeWord;
                cp0Epc:   bus.readData = {epcReg, 2'b00};
                cp0PrId:  bus.readData = prIdValue;
                default:  bus.readData = 32'h0000_0000;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            im         <= imReset;
            exl        <= exlReset;
            ie         <= ieReset;
            bd         <= 1'b0;
            ip         <= 6'b000000;
            excCodeReg <= excNone;
            epcReg     <= textStart[31:2];
        end else begin
            // Pending lines are visible in Cause whether masked or not
            ip <= bus.hwInt;
            if (entry) begin
                exl        <= 1'b1;
                excCodeReg <= interrupt ? excInt : bus.exc;
                bd         <= bus.macroBd;
                epcReg     <= entryPc[31:2];
            end else if (isEret) begin
                exl        <= 1'b0;
                excCodeReg <= excNone;
                bd         <= 1'b0;
            end else if (isMtc0 && bus.regId == cp0Sr) begin
                {im, exl, ie} <= {bus.wData[15:10], bus.wData[1], bus.wData[0]};
            end else if (isMtc0 && bus.regId == cp0Epc) begin
                epcReg <= bus.wData[31:2];
            end
        end
    end

    // Controller cannot take a kernel entry and a return at once
    entryNotEret: assert property (@(posedge clk) disable iff (reset) !(entry && isEret))
        else $error("kernel entry and ERET requested in the same cycle");

endmodule

// ==== verilog/cp0Port.sv ====
`timescale 1ns/10ps

interface cp0Port;
    import mipsIsaPkg::*;
    import memMapPkg::*;

    // Access request from the stage
    memOp        op;
    cp0RegId     regId;
    logic [31:0] wData;
    excCode      exc;
    logic [31:0] macroPc;
    logic        macroBd;
    logic [5:0]  hwInt;

    // Answer from the coprocessor
    kCtrlKind    kCtrl;
    logic        isBd;
    logic [31:2] epc;
    logic [31:0] readData;

    modport stage (
        output op, regId, wData, exc, macroPc, macroBd, hwInt,
        input  kCtrl, isBd, epc, readData
    );

    modport cop (
        input  op, regId, wData, exc, macroPc, macroBd, hwInt,
        output kCtrl, isBd, epc, readData
    );

endinterface

// ==== verilog/dataMemory.sv ====
`timescale 1ns/10ps

module dataMemory #(
    parameter int memWords = 3072
) (
    input  logic        clk,
    input  logic [29:0] wordAddr,
    input  logic [3:0]  byteEn,
    input  logic [31:0] wData,
    output logic [31:0] rData
);
    import memMapPkg::*;

    localparam int indexBits = $clog2(memWords);

    logic [31:0]          mem [memWords];
    logic [indexBits-1:0] index;
    logic                 inRange;

    assign index   = wordAddr[indexBits-1:0];
    assign inRange = (wordAddr < memWords);

    initial begin
        for (int i = 0; i < memWords; i++) begin
            mem[i] = 32'h0000_0000;
        end
        // RAM depth has to cover exactly the data range
        assert (memWords * 4 == dataEnd - dataStart)
            else $error("memWords %0d does not match the data range", memWords);
    end

    // Byte lanes are written independently
    always @(posedge clk) begin
        if (inRange) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteEn[lane]) begin
                    mem[index][lane*8 +: 8] <= wData[lane*8 +: 8];
                end
            end
        end
    end

    assign rData = inRange ? mem[index] : 32'h0000_0000;

endmodule

// ==== verilog/memMapPkg.sv ====
package memMapPkg;

    // Data range, upper bound exclusive
    localparam logic [31:0] dataStart = 32'h0000_0000;
    localparam logic [31:0] dataEnd   = 32'h0000_3000;

    // Start of the instruction area
    localparam logic [31:0] textStart = 32'h0000_3000;

    // Processor id word
    localparam logic [31:0] prIdValue = 32'h0000_4d50;

    // Request to the pipeline controller
    typedef enum logic [1:0] {
        kCtrlNone  = 2'd0,
        kCtrlKtext = 2'd1,
        kCtrlEret  = 2'd2
    } kCtrlKind;

    // SR fields after reset, all interrupt lines unmasked
    localparam logic [5:0] imReset  = 6'b111111;
    localparam logic       exlReset = 1'b0;
    localparam logic       ieReset  = 1'b1;

endpackage

// ==== verilog/memStage.sv ====
`timescale 1ns/10ps

module memStage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  memDisable,
    input  mipsIsaPkg::memOp      op,
    input  logic [31:0]           pc,
    input  mipsIsaPkg::excCode    excIn,
    input  logic [31:0]           aluOut,
    input  logic [31:0]           rtData,
    input  logic [4:0]            rtAddr,
    input  logic [4:0]            rdAddr,
    input  logic [4:0]            destAddr,
    input  logic [31:0]           destData,
    input  mipsIsaPkg::tNewType   tNew,
    input  logic [4:0]            wbAddr,
    input  logic [31:0]           wbData,
    output logic [29:0]           memWordAddr,
    output logic [3:0]            memByteEn,
    output logic [31:0]           memWData,
    input  logic [31:0]           memRData,
    cp0Port.stage                 cop,
    input  logic [31:0]           macroPc,
    input  logic                  macroBd,
    input  logic [5:0]            hwInt,
    output memMapPkg::kCtrlKind   kCtrl,
    output logic [31:2]           epc,
    output logic                  isBd,
    output mipsIsaPkg::memOp      opWb,
    output logic [31:0]           pcWb,
    output logic [31:0]           memWordWb,
    output logic [1:0]            offsetWb,
    output logic [4:0]            destAddrWb,
    output logic [31:0]           destDataWb,
    output mipsIsaPkg::tNewType   tNewWb
);
    import mipsIsaPkg::*;

    logic [31:0] rtFwd;
    logic [1:0]  offset;
    excCode      alignExc;
    logic        isLoad;
    logic [31:0] result;
    tNewType     tNewNext;

    // Write-back result overrides the stale register value, r0 excluded
    assign rtFwd = (wbAddr == rtAddr && wbAddr != 5'd0) ? wbData : rtData;

    // Stores wait out a stall since rtFwd may still change
    storeAlign align (
        .op          (op),
        .addr        (aluOut),
        .wData       (rtFwd),
        .enable      (!memDisable && !stall),
        .wordAddr    (memWordAddr),
        .byteEn      (memByteEn),
        .alignedData (memWData),
        .offset      (offset),
        .exc         (alignExc)
    );

    assign cop.op      = op;
    assign cop.regId   = rdAddr;
    assign cop.wData   = rtFwd;
    assign cop.exc     = (excIn != excNone) ? excIn : alignExc;
    assign cop.macroPc = macroPc;
    assign cop.macroBd = macroBd;
    assign cop.hwInt   = hwInt;

    assign kCtrl = cop.kCtrl;
    assign epc   = cop.epc;
    assign isBd  = cop.isBd;

    assign isLoad = (op == opLw) || (op == opLh) || (op == opLhu) || (op == opLb) || (op == opLbu);
    assign result = (op == opMfc0) ? cop.readData : (isLoad ? memRData : destData);

    assign tNewNext = (tNew != 2'd0) ? tNew - 2'd1 : 2'd0;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            opWb       <= opNop;
            pcWb       <= 32'h0000_0000;
            memWordWb  <= 32'h0000_0000;
            offsetWb   <= 2'b00;
            destAddrWb <= 5'd0;
            destDataWb <= 32'h0000_0000;
            tNewWb     <= 2'd0;
        end else if (!stall) begin
            opWb       <= op;
            pcWb       <= pc;
            memWordWb  <= memRData;
            offsetWb   <= offset;
            destAddrWb <= destAddr;
            destDataWb <= result;
            tNewWb     <= tNewNext;
        end
    end

endmodule

// ==== verilog/memSubsystem.sv ====
`timescale 1ns/10ps

module memSubsystem #(
    parameter int memWords = 3072
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  memDisable,
    input  mipsIsaPkg::memOp      op,
    input  logic [31:0]           pc,
    input  mipsIsaPkg::excCode    excIn,
    input  logic [31:0]           aluOut,
    input  logic [31:0]           rtData,
    input  logic [4:0]            rtAddr,
    input  logic [4:0]            rdAddr,
    input  logic [4:0]            destAddr,
    input  logic [31:0]           destData,
    input  mipsIsaPkg::tNewType   tNew,
    input  logic [4:0]            wbAddr,
    input  logic [31:0]           wbData,
    input  logic [31:0]           macroPc,
    input  logic                  macroBd,
    input  logic [5:0]            hwInt,
    output mipsIsaPkg::memOp      opWb,
    output logic [31:0]           pcWb,
    output logic [31:0]           memWordWb,
    output logic [1:0]            offsetWb,
    output logic [4:0]            destAddrWb,
    output logic [31:0]           destDataWb,
    output mipsIsaPkg::tNewType   tNewWb,
    output memMapPkg::kCtrlKind   kCtrl,
    output logic [31:2]           epc,
    output logic                  isBd
);

    logic [29:0] memWordAddr;
    logic [3:0]  memByteEn;
    logic [31:0] memWData;
    logic [31:0] memRData;

    cp0Port cpBus ();

    memStage stage (
        .clk(clk), .reset(reset), .stall(stall), .flush(flush), .memDisable(memDisable),
        .op(op), .pc(pc), .excIn(excIn), .aluOut(aluOut),
        .rtData(rtData), .rtAddr(rtAddr), .rdAddr(rdAddr),
        .destAddr(destAddr), .destData(destData), .tNew(tNew),
        .wbAddr(wbAddr), .wbData(wbData),
        .memWordAddr(memWordAddr), .memByteEn(memByteEn),
        .memWData(memWData), .memRData(memRData),
        .cop(cpBus.stage),
        .macroPc(macroPc), .macroBd(macroBd), .hwInt(hwInt),
        .kCtrl(kCtrl), .epc(epc), .isBd(isBd),
        .opWb(opWb), .pcWb(pcWb), .memWordWb(memWordWb), .offsetWb(offsetWb),
        .destAddrWb(destAddrWb), .destDataWb(destDataWb), .tNewWb(tNewWb)
    );

    coprocessor0 cp0 (
        .clk   (clk),
        .reset (reset),
        .bus   (cpBus.cop)
    );

    dataMemory #(
        .memWords (memWords)
    ) ram (
        .clk      (clk),
        .wordAddr (memWordAddr),
        .byteEn   (memByteEn),
        .wData    (memWData),
        .rData    (memRData)
    );

endmodule

// ==== verilog/mipsIsaPkg.sv ====
package mipsIsaPkg;

    // Decoded opcodes as seen by the memory stage
    // ALU covers every instruction that only passes its result through
    typedef enum logic [3:0] {
        opNop  = 4'd0,
        opLw   = 4'd1,
        opLh   = 4'd2,
        opLhu  = 4'd3,
        opLb   = 4'd4,
        opLbu  = 4'd5,
        opSw   = 4'd6,
        opSh   = 4'd7,
        opSb   = 4'd8,
        opMfc0 = 4'd9,
        opMtc0 = 4'd10,
        opEret = 4'd11,
        opAlu  = 4'd12
    } memOp;

    // Exception codes as stored in Cause.ExcCode
    typedef enum logic [4:0] {
        excNone = 5'd0,
        excAdel = 5'd4,
        excAdes = 5'd5,
        excRi   = 5'd10,
        excOv   = 5'd12
    } excCode;

    // Interrupts share code zero with the no-exception case
    localparam excCode excInt = excNone;

    // Coprocessor 0 register numbers
    typedef logic [4:0] cp0RegId;

    localparam cp0RegId cp0Sr    = 5'd12;
    localparam cp0RegId cp0Cause = 5'd13;
    localparam cp0RegId cp0Epc   = 5'd14;
    localparam cp0RegId cp0PrId  = 5'd15;

    // Cycles until a result is ready, used by the hazard logic
    typedef logic [1:0] tNewType;

endpackage

// ==== verilog/storeAlign.sv ====
`timescale 1ns/10ps

module storeAlign (
    input  mipsIsaPkg::memOp   op,
    input  logic [31:0]        addr,
    input  logic [31:0]        wData,
    input  logic               enable,
    output logic [29:0]        wordAddr,
    output logic [3:0]         byteEn,
    output logic [31:0]        alignedData,
    output logic [1:0]         offset,
    output mipsIsaPkg::excCode exc
);
    import mipsIsaPkg::*;
    import memMapPkg::*;

    logic       isLoad;
    logic       isStore;
    logic       inData;
    logic       misaligned;
    logic [3:0] lanes;

    assign wordAddr = addr[31:2];
    assign offset   = addr[1:0];

    assign isLoad  = (op == opLw) || (op == opLh) || (op == opLhu) || (op == opLb) || (op == opLbu);
    assign isStore = (op == opSw) || (op == opSh) || (op == opSb);
    assign inData  = (addr >= dataStart) && (addr < dataEnd);

    // Words need both low bits clear, halves only bit 0
    assign misaligned = ((op == opLw || op == opSw) && offset != 2'b00)
        || ((op == opLh || op == opLhu || op == opSh) && offset[0]);

    always_comb begin
        exc = excNone;
        if (isLoad && (misaligned || !inData)) begin
            exc = excAdel;
        end else if (isStore && (misaligned || !inData)) begin
            exc = excAdes;
        end
    end

    // Move the store data into the addressed lanes
    always_comb begin
        lanes       = 4'b0000;
        alignedData = wData;
        case (op)
            opSw: lanes = 4'b1111;
            opSh: begin
                lanes       = offset[1] ? 4'b1100 : 4'b0011;
                alignedData = wData << {offset[1], 4'b0000};
            end
            opSb: begin
                lanes       = 4'b0001 << offset;
                alignedData = wData << {offset, 3'b000};
            end
            default: lanes = 4'b0000;
        endcase
    end

    assign byteEn = (enable && exc == excNone) ? lanes : 4'b0000;

    // Loads, coprocessor ops and ALU ops must never touch the RAM
    always_comb begin
        if (!isStore) begin
            assert (byteEn == 4'b0000)
                else $error("byte enables raised for non-store op %s", op.name());
        end
    end

endmodule
